// File: av_pkg.sv
////////////////////
// shared constants, vector types and bus structs for the av generators
// imported by the rtl modules and by the testbench
////////////////////

`default_nettype none

package av_pkg;

    ////////////////////
    // video raster
    ////////////////////

    // 400 x 512 clocks at 12.288 mhz gives one frame per 204800 clocks, 60 hz
    localparam int h_total = 400;
    localparam int h_active = 320;
    // columns before the first visible pixel
    localparam int h_bporch = 10;

    localparam int v_total = 512;
    localparam int v_active = 240;
    // lines before the first visible line
    localparam int v_bporch = 10;

    // hs sits a few clocks after vs so the two never coincide
    localparam int hs_column = 3;

    // flat gray for the visible window
    localparam int fill_level = 60;

    ////////////////////
    // audio
    ////////////////////

    // mclk cycles per sclk period, 12.288 mhz down to 3.072 mhz
    localparam int sclk_div = 4;
    // bit slots per channel, 64 per stereo frame, 48 khz
    localparam int slot_count = 32;
    // active bits per channel, rest of the slots are padding
    localparam int sample_width = 16;

    ////////////////////
    // vector types
    ////////////////////

    // column or line position
    typedef logic [9:0] raster_count_t;
    typedef logic [7:0] color_t;
    // signed pcm, two's complement
    typedef logic signed [15:0] audio_sample_t;
    // bit slot within one channel
    typedef logic [4:0] slot_index_t;

    ////////////////////
    // structs
    ////////////////////

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    // pixel plus sync, all registered together
    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic hs;
        logic vs;
    } video_out_t;

    // the three i2s pins to the dac
    typedef struct packed {
        logic sclk;
        logic lrck;
        logic dac;
    } i2s_bus_t;

    // clock generator to serializer
    typedef struct packed {
        // high in the mclk cycle that ends with the sclk fall
        logic shift_en;
        // coincides with the shift_en at which lrck drops to left
        logic frame_start;
        logic sclk;
        logic lrck;
        // slot of the bit that goes out at the next shift_en
        slot_index_t slot;
    } i2s_timing_t;

endpackage

`default_nettype wire

// File: video_raster.sv
////////////////////
// free-running 400 x 512 raster with a 320 x 240 gray window
// one-cycle vs at the origin, one-cycle hs at column 3 of each line
////////////////////

`default_nettype none

module video_raster (
    input  wire logic           audgen_mclk,
    input  wire logic           reset_n,
    output av_pkg::video_out_t  video
);

    import av_pkg::*;

    raster_count_t h_cnt;
    raster_count_t v_cnt;
    logic          h_last;
    logic          v_last;
    logic          h_vis;
    logic          v_vis;
    logic          active;

    ////////////////////
    // counters
    ////////////////////

    // end of line and end of frame
    assign h_last = (h_cnt == raster_count_t'(h_total - 1));
    assign v_last = (v_cnt == raster_count_t'(v_total - 1));

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                // line counter only moves at end of line
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // window decode
    ////////////////////

    // columns 10..329
    assign h_vis = (h_cnt >= raster_count_t'(h_bporch)) &&
                   (h_cnt < raster_count_t'(h_bporch + h_active));
    // lines 10..249
    assign v_vis = (v_cnt >= raster_count_t'(v_bporch)) &&
                   (v_cnt < raster_count_t'(v_bporch + v_active));
    assign active = h_vis && v_vis;

    ////////////////////
    // output register
    ////////////////////

    // everything lands one clock after the counter state it describes
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video <= '0;
        end else begin
            // new frame at the origin
            video.vs <= (h_cnt == '0) && (v_cnt == '0);
            // new line, a few clocks into the porch
            video.hs <= (h_cnt == raster_count_t'(hs_column));
            video.de <= active;
            // gray inside the window, black everywhere else
            if (active) begin
                video.rgb.r <= color_t'(fill_level);
                video.rgb.g <= color_t'(fill_level);
                video.rgb.b <= color_t'(fill_level);
            end else begin
                video.rgb <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: i2s_clock_gen.sv
////////////////////
// i2s bit clock and word clock from mclk
// sclk = mclk / 4, 32 slots per channel, lrck low is left
////////////////////

`default_nettype none

module i2s_clock_gen (
    input  wire logic            audgen_mclk,
    input  wire logic            reset_n,
    output av_pkg::i2s_timing_t  timing
);

    import av_pkg::*;

    logic [1:0]  div;
    slot_index_t slot_cnt;
    logic        lrck;
    logic        shift_en;
    logic        frame_start;
    logic        fall_next;
    logic        slot_wrap;

    // div runs 0,1,2,3 and sclk is its msb, low 2 clocks then high 2
    // at div == 2 the following cycle is the last high one
    assign fall_next = (div == 2'(sclk_div - 2));
    // slot on the line is the last one of the channel
    assign slot_wrap = (slot_cnt == slot_index_t'(slot_count - 1));

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div         <= '0;
            slot_cnt    <= '0;
            lrck        <= 1'b0;
            shift_en    <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            div         <= div + 1'b1;
            shift_en    <= fall_next;
            // right channel ending, next word is left
            frame_start <= fall_next && slot_wrap && lrck;
            // slot, lrck and sclk all change on the same edge
            if (shift_en) begin
                slot_cnt <= slot_cnt + 1'b1;
                if (slot_wrap) begin
                    lrck <= ~lrck;
                end
            end
        end
    end

    assign timing.shift_en    = shift_en;
    assign timing.frame_start = frame_start;
    assign timing.sclk        = div[1];
    assign timing.lrck        = lrck;
    // serializer needs the slot after the coming fall
    assign timing.slot        = slot_cnt + 1'b1;

endmodule

`default_nettype wire

// File: i2s_serializer.sv
////////////////////
// i2s data path, msb first with the one-bit delay after lrck
// latches a stereo pair per frame, drives dac on the sclk fall
////////////////////

`default_nettype none

module i2s_serializer (
    input  wire logic                  audgen_mclk,
    input  wire logic                  reset_n,
    input  wire av_pkg::i2s_timing_t   timing,
    input  wire av_pkg::audio_sample_t audio_l,
    input  wire av_pkg::audio_sample_t audio_r,
    output logic                       dac
);

    import av_pkg::*;

    audio_sample_t held_l;
    audio_sample_t held_r;
    audio_sample_t word;
    logic [3:0]    bit_sel;
    logic          in_data;
    logic          next_bit;

    ////////////////////
    // sample latch
    ////////////////////

    // both channels taken together so a frame never mixes two pairs
    // silent until the first frame_start
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            held_l <= '0;
            held_r <= '0;
        end else if (timing.frame_start) begin
            held_l <= audio_l;
            held_r <= audio_r;
        end
    end

    ////////////////////
    // bit select
    ////////////////////

    // lrck already shows the channel of slots 1..16
    assign word = timing.lrck ? held_r : held_l;

    // slot 0 is the i2s delay bit, 17..31 are padding
    assign in_data = (timing.slot != '0) &&
                     (timing.slot <= slot_index_t'(sample_width));

    // slot 1 -> bit 15 ... slot 16 -> bit 0
    assign bit_sel  = 4'(sample_width - int'(timing.slot));
    assign next_bit = in_data & word[bit_sel];

    // new bit on the same edge that takes sclk low
    // stable again by the next rising sclk
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            dac <= 1'b0;
        end else if (timing.shift_en) begin
            dac <= next_bit;
        end
    end

endmodule

`default_nettype wire

// File: av_out_top.sv
////////////////////
// top level with the video raster and i2s audio on the mclk domain
// samples come in as levels on audio_l / audio_r
////////////////////

`default_nettype none

module av_out_top (
    input  wire logic                  audgen_mclk,
    input  wire logic                  reset_n,
    input  wire av_pkg::audio_sample_t audio_l,
    input  wire av_pkg::audio_sample_t audio_r,
    output av_pkg::video_out_t         video,
    output av_pkg::i2s_bus_t           i2s
);

    import av_pkg::*;

    // strobes and slot position between the audio blocks
    i2s_timing_t timing;
    logic        dac;

    ////////////////////
    // video
    ////////////////////

    video_raster u_video (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .video       (video)
    );

    ////////////////////
    // audio
    ////////////////////

    i2s_clock_gen u_i2s_clk (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .timing      (timing)
    );

    i2s_serializer u_i2s_ser (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .timing      (timing),
        .audio_l     (audio_l),
        .audio_r     (audio_r),
        .dac         (dac)
    );

    // clocks from the generator, data from the serializer
    assign i2s.sclk = timing.sclk;
    assign i2s.lrck = timing.lrck;
    assign i2s.dac  = dac;

endmodule

`default_nettype wire

// File: av_out_assert.sv
////////////////////
// concurrent checks on the video and i2s pins of av_out_top
// attached to every av_out_top instance by the bind at the bottom
////////////////////

`default_nettype none

module av_out_assert (
    input wire logic               audgen_mclk,
    input wire logic               reset_n,
    input wire av_pkg::video_out_t video,
    input wire av_pkg::i2s_bus_t   i2s
);

    ////////////////////
    // video
    ////////////////////

    // line sync is a single-cycle pulse
    hs_single: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video.hs |=> !video.hs)
        else $error("hs high for two cycles in a row");

    // frame sync too
    vs_single: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video.vs |=> !video.vs)
        else $error("vs high for two cycles in a row");

    // blanking always black
    blank_black: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !video.de |-> (video.rgb == '0))
        else $error("rgb not zero while de is low");

    ////////////////////
    // audio
    ////////////////////

    // word clock only moves together with the bit clock fall
    lrck_on_fall: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(i2s.lrck) |-> $fell(i2s.sclk))
        else $error("lrck changed without an sclk fall");

endmodule

bind av_out_top av_out_assert u_check (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .video       (video),
    .i2s         (i2s)
);

`default_nettype wire

// File: tb_av_out.sv
////////////////////
// testbench for av_out_top
// runs the tests listed in av_out_tests.txt against the video and i2s pins
// one result line per test, then the totals
////////////////////

`default_nettype none

module tb_av_out;

    import av_pkg::*;

    localparam int clk_period = 100;
    // mclk cycles in one video frame
    localparam int frame_len = 204800;
    // per-test allowance for the watchdog
    localparam longint test_budget = 204800 + 1024;

    logic          audgen_mclk;
    logic          reset_n;
    audio_sample_t audio_l;
    audio_sample_t audio_r;
    video_out_t    video;
    i2s_bus_t      i2s;

    // test table from the file
    string       t_name[$];
    string       t_kind[$];
    logic [15:0] t_left[$];
    logic [15:0] t_right[$];
    logic [31:0] t_exp[$];
    bit          tests_loaded;

    int pass_count;
    int fail_count;

    // frame scan results
    int          run_first;
    int          run_odd;
    int          de_lines_seen;
    logic [23:0] gray_first;
    logic [23:0] gray_bad;
    bit          gray_seen;
    bit          gray_ok;
    logic [23:0] black_or;

    // i2s capture results
    i2s_bus_t    i2s_prev;
    logic [15:0] cap_l;
    logic [15:0] cap_r;
    int          pad_ones;
    int          lrck_len;
    int          sclk_min;
    int          sclk_max;

    av_out_top uut (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_l     (audio_l),
        .audio_r     (audio_r),
        .video       (video),
        .i2s         (i2s)
    );

    always #(clk_period / 2) audgen_mclk = ~audgen_mclk;

    ////////////////////
    // helpers
    ////////////////////

    // all sampling on the falling mclk edge, outputs settled there
    task automatic tick();
        i2s_prev = i2s;
        @(negedge audgen_mclk);
    endtask

    function automatic logic pulse_now(input bit use_vs);
        return use_vs ? video.vs : video.hs;
    endfunction

    // cycles from one sync pulse to the next
    task automatic measure_gap(input bit use_vs, output int gap);
        int n;
        while (!pulse_now(use_vs)) @(negedge audgen_mclk);
        n = 0;
        do begin
            @(negedge audgen_mclk);
            n++;
        end while (!pulse_now(use_vs));
        gap = n;
    endtask

    // one whole frame from vs, ends on the next vs
    task automatic scan_frame();
        int   run;
        int   i;
        logic de_prev;
        run_first = 0;
        run_odd = 0;
        de_lines_seen = 0;
        gray_first = '0;
        gray_bad = '0;
        gray_seen = 0;
        gray_ok = 1;
        black_or = '0;
        run = 0;
        de_prev = 1'b0;
        while (!video.vs) @(negedge audgen_mclk);
        for (i = 0; i < frame_len; i++) begin
            if (video.de) begin
                run++;
                // first visible pixel sets the reference color
                if (!gray_seen) begin
                    gray_first = video.rgb;
                    gray_seen = 1;
                end else if (gray_ok && video.rgb != gray_first) begin
                    gray_bad = video.rgb;
                    gray_ok = 0;
                end
            end else begin
                black_or |= video.rgb;
                // end of a visible run
                if (de_prev) begin
                    de_lines_seen++;
                    if (de_lines_seen == 1) begin
                        run_first = run;
                    end else if (run != run_first && run_odd == 0) begin
                        run_odd = run;
                    end
                    run = 0;
                end
            end
            de_prev = video.de;
            @(negedge audgen_mclk);
        end
    endtask

    // drive a pair, let two frames start, then decode one stereo frame
    task automatic run_audio(input logic [15:0] l, input logic [15:0] r);
        int falls;
        int slot;
        int cyc;
        int last_rise;
        int gap;
        bit right_ch;
        bit done;
        @(posedge audgen_mclk);
        audio_l <= l;
        audio_r <= r;
        @(negedge audgen_mclk);
        falls = 0;
        while (falls < 2) begin
            tick();
            if (i2s_prev.lrck && !i2s.lrck) begin
                falls++;
            end
        end
        cap_l = '0;
        cap_r = '0;
        pad_ones = 0;
        slot = 0;
        cyc = 0;
        last_rise = -1;
        sclk_min = 1000000;
        sclk_max = 0;
        right_ch = 0;
        done = 0;
        while (!done) begin
            tick();
            cyc++;
            // data read on the sclk rise
            if (!i2s_prev.sclk && i2s.sclk) begin
                if (last_rise >= 0) begin
                    gap = cyc - last_rise;
                    if (gap < sclk_min) sclk_min = gap;
                    if (gap > sclk_max) sclk_max = gap;
                end
                last_rise = cyc;
                // slot 0 is the delay bit, 1..16 msb first
                if (slot >= 1 && slot <= 16) begin
                    if (right_ch) begin
                        cap_r = {cap_r[14:0], i2s.dac};
                    end else begin
                        cap_l = {cap_l[14:0], i2s.dac};
                    end
                end else if (i2s.dac) begin
                    pad_ones++;
                end
                slot++;
            end
            if (!i2s_prev.lrck && i2s.lrck) begin
                right_ch = 1;
                slot = 0;
            end
            if (i2s_prev.lrck && !i2s.lrck) begin
                done = 1;
            end
        end
        lrck_len = cyc;
    endtask

    task automatic load_tests(output bit ok);
        int          fd;
        int          got;
        string       line;
        string       name;
        string       kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e;
        ok = 0;
        fd = $fopen("av_out_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                // skip blank and comment lines
                if (got > 0 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%s %s %h %h %h", name, kind, a, b, e);
                    if (got == 5) begin
                        t_name.push_back(name);
                        t_kind.push_back(kind);
                        t_left.push_back(a[15:0]);
                        t_right.push_back(b[15:0]);
                        t_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
            ok = (t_name.size() > 0);
        end
    endtask

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act);
            fail_count++;
        end else begin
            $display("pass     %s value 0x%0h", name, act);
            pass_count++;
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        bit          ok;
        int          idx;
        int          gap;
        logic [31:0] exp;
        logic [31:0] act;
        audgen_mclk = 1'b0;
        reset_n = 1'b0;
        audio_l = '0;
        audio_r = '0;
        i2s_prev = '0;
        pass_count = 0;
        fail_count = 0;
        tests_loaded = 0;
        load_tests(ok);
        if (!ok) begin
            $display("could not read any test from av_out_tests.txt");
            $display("Test FAILED");
            $finish;
        end else begin
            tests_loaded = 1;
            repeat (3) @(posedge audgen_mclk);
            reset_n <= 1'b1;
            @(negedge audgen_mclk);
            for (idx = 0; idx < t_name.size(); idx++) begin
                exp = t_exp[idx];
                act = '0;
                if (t_kind[idx] == "hs_period") begin
                    measure_gap(0, gap);
                    act = gap;
                end else if (t_kind[idx] == "vs_period") begin
                    measure_gap(1, gap);
                    act = gap;
                end else if (t_kind[idx] == "de_run") begin
                    scan_frame();
                    // a wrong first run or any run that differs from it shows up
                    if (run_odd != 0 && run_first == exp) begin
                        act = run_odd;
                    end else begin
                        act = run_first;
                    end
                end else if (t_kind[idx] == "de_lines") begin
                    scan_frame();
                    act = de_lines_seen;
                end else if (t_kind[idx] == "gray") begin
                    scan_frame();
                    // expected level on all three channels
                    exp = {8'h00, exp[7:0], exp[7:0], exp[7:0]};
                    // a wrong first pixel or any pixel that differs from it shows up
                    if (!gray_ok && gray_first == exp[23:0]) begin
                        act = gray_bad;
                    end else begin
                        act = gray_first;
                    end
                end else if (t_kind[idx] == "black") begin
                    scan_frame();
                    act = black_or;
                end else if (t_kind[idx] == "audio") begin
                    run_audio(t_left[idx], t_right[idx]);
                    act = {cap_l, cap_r};
                end else if (t_kind[idx] == "pad_zero") begin
                    run_audio(t_left[idx], t_right[idx]);
                    act = pad_ones;
                end else if (t_kind[idx] == "lrck_period") begin
                    run_audio(t_left[idx], t_right[idx]);
                    act = lrck_len;
                end else if (t_kind[idx] == "sclk_period") begin
                    run_audio(t_left[idx], t_right[idx]);
                    // show the odd period if the two extremes differ
                    if (sclk_min == sclk_max || sclk_min != exp) begin
                        act = sclk_min;
                    end else begin
                        act = sclk_max;
                    end
                end else begin
                    $display("test %s has an unknown kind %s", t_name[idx], t_kind[idx]);
                    fail_count++;
                    continue;
                end
                report(t_name[idx], exp, act);
            end
            $display("%0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

    ////////////////////
    // watchdog
    ////////////////////

    // one frame plus margin for each test
    initial begin
        wait (tests_loaded);
        #(longint'(t_name.size()) * test_budget * clk_period);
        $display("timeout, the tests did not finish in the allowed time");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: av_out_tests.txt
# columns: name kind left right expected, the last three in hex
# audio expects {left, right}, the other kinds a cycle count, a level or zero
hs_interval  hs_period   0000 0000 190
vs_interval  vs_period   0000 0000 32000
de_run_len   de_run      0000 0000 140
de_line_cnt  de_lines    0000 0000 f0
gray_fill    gray        0000 0000 3c
black_border black       0000 0000 0
audio_basic  audio       1234 abcd 1234abcd
audio_msb    audio       8000 0001 80000001
audio_ones   audio       ffff ffff ffffffff
audio_mixed  audio       7fff 8000 7fff8000
audio_zero   audio       0000 0000 00000000
pad_ones     pad_zero    ffff ffff 0
lrck_len     lrck_period a5a5 5a5a 100
sclk_len     sclk_period 0f0f f0f0 4

// File: sim.f
av_pkg.sv
video_raster.sv
i2s_clock_gen.sv
i2s_serializer.sv
av_out_top.sv
av_out_assert.sv
tb_av_out.sv
